// ==== src/spi_pkg.sv ====
// shared definitions for the SPI slave and its CPU register port
// holds the register map, the default word width, the version
// constant and the reset values of the flags
// RTL and bench refer to these by scoped name
package spi_pkg;

   // default data word width, overridden through DATA_W at the top
   localparam int spi_data_w = 32;

   // register address width
   localparam int spi_addr_w = 3;

   // register map
   // ready flag in bit 0, read only
   localparam logic [spi_addr_w-1:0] spi_addr_ready    = 3'd0;
   // last received word, read only
   localparam logic [spi_addr_w-1:0] spi_addr_rx       = 3'd1;
   // word to transmit, write only
   localparam logic [spi_addr_w-1:0] spi_addr_tx       = 3'd2;
   // any write starts a soft reset
   localparam logic [spi_addr_w-1:0] spi_addr_soft_rst = 3'd3;
   // version constant, read only
   localparam logic [spi_addr_w-1:0] spi_addr_version  = 3'd4;
   // scratch word for bus tests
   localparam logic [spi_addr_w-1:0] spi_addr_scratch  = 3'd5;

   // returned at spi_addr_version, cut or padded to the data width
   localparam logic [31:0] spi_version = 32'h0001_0200;

   // reset values
   // ss idle means ready
   localparam logic spi_ready_rst = 1'b1;
   // soft reset flop comes out of hard reset set, stretching rst_core
   localparam logic spi_soft_rst_init = 1'b1;

endpackage

// ==== src/spi_cdc_sync.sv ====
// two-flop synchronizer for any payload type
// moves a value into the domain of clk; both stages reset
// asynchronously to RESET_VAL
// used for the data words and for the ready bit of the SPI slave
`timescale 1ns/1ps

module spi_cdc_sync #(
   parameter type T         = logic,
   parameter T    RESET_VAL = '0
) (
   input  logic clk,
   input  logic rst,
   input  T     d,
   output T     q
);

   // first stage may go metastable, never read outside
   T meta_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         meta_q <= RESET_VAL;
         q      <= RESET_VAL;
      end else begin
         meta_q <= d;
         q      <= meta_q;
      end
   end

endmodule

// ==== src/spi_reg_file.sv ====
// CPU side register file of the SPI slave, clocked by clk
// decodes sel/read/write strobes on a small address space, holds the
// transmit and scratch words, generates the self-clearing soft reset
// and returns the selected register on data_out combinationally
// rst_core combines hard and soft reset for both clock domains
`timescale 1ns/1ps

module spi_reg_file #(
   parameter int DATA_W = 32
) (
   input  logic                           clk,
   input  logic                           rst_int,

   // CPU bus
   input  logic [spi_pkg::spi_addr_w-1:0] address,
   input  logic [DATA_W-1:0]              data_in,
   input  logic                           sel,
   input  logic                           read,
   input  logic                           write,
   output logic [DATA_W-1:0]              data_out,

   // from the SPI side, already synchronized to clk
   input  logic [DATA_W-1:0]              rx_word,
   input  logic                           ready,

   // to the SPI side
   output logic [DATA_W-1:0]              tx_word,
   output logic                           rst_core
);

   // write enables
   logic              tx_en;
   logic              scratch_en;
   logic              soft_rst_en;

   // soft reset pulse
   logic              soft_rst;

   // scratch word for bus tests
   logic [DATA_W-1:0] scratch;

   // hard or soft reset
   assign rst_core = rst_int | soft_rst;

   // write decode
   always_comb begin
      tx_en       = 1'b0;
      scratch_en  = 1'b0;
      soft_rst_en = 1'b0;
      if (sel && write) begin
         case (address)
            spi_pkg::spi_addr_tx:       tx_en       = 1'b1;
            spi_pkg::spi_addr_soft_rst: soft_rst_en = 1'b1;
            spi_pkg::spi_addr_scratch:  scratch_en  = 1'b1;
            default: ;
         endcase
      end
   end

   // read mux, zero when not selected or unmapped
   always_comb begin
      data_out = '0;
      if (sel && read) begin
         case (address)
            spi_pkg::spi_addr_ready:   data_out = DATA_W'(ready);
            spi_pkg::spi_addr_rx:      data_out = rx_word;
            spi_pkg::spi_addr_version: data_out = DATA_W'(spi_pkg::spi_version);
            spi_pkg::spi_addr_scratch: data_out = scratch;
            default:                   data_out = '0;
         endcase
      end
   end

   // self-clearing soft reset
   // only the hard reset may clear it, otherwise it would reset itself
   // a write during the pulse is dropped so it never lasts two cycles
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         soft_rst <= spi_pkg::spi_soft_rst_init;
      end else begin
         soft_rst <= soft_rst_en & ~soft_rst;
      end
   end

   // transmit word, picked up by the sclk side while ss is idle
   always_ff @(posedge clk or posedge rst_core) begin
      if (rst_core) begin
         tx_word <= '0;
      end else if (tx_en) begin
         tx_word <= data_in;
      end
   end

   // scratch register
   always_ff @(posedge clk or posedge rst_core) begin
      if (rst_core) begin
         scratch <= '0;
      end else if (scratch_en) begin
         scratch <= data_in;
      end
   end

endmodule

// ==== src/spi_shift_engine.sv ====
// SPI side of the slave, clocked by sclk
// mode is fixed: receive on rising sclk, transmit on falling sclk,
// both LSB first, one data word per frame while ss is low
// rst is asynchronous from the clk domain and is released here
// through a two-flop synchronizer, which needs sclk to be running
`timescale 1ns/1ps

module spi_shift_engine #(
   parameter int DATA_W = 32
) (
   input  logic              sclk,
   input  logic              rst,

   // SPI pins
   input  logic              ss,
   input  logic              mosi,
   output logic              miso,

   // word to send, synchronized to sclk
   input  logic [DATA_W-1:0] tx_word,

   // sclk domain results
   output logic [DATA_W-1:0] rx_word,
   output logic              ready,

   // synchronized reset for the sclk domain
   output logic              spi_rst
);

   // reset release chain
   logic [1:0]        rst_sync;

   // first ss sample
   logic              ss_q;

   // transmit shifter
   logic [DATA_W-1:0] tx_shift;

   // assert at once, release after two rising sclk edges
   always_ff @(posedge sclk or posedge rst) begin
      if (rst) begin
         rst_sync <= 2'b11;
      end else begin
         rst_sync <= {rst_sync[0], 1'b0};
      end
   end

   assign spi_rst = rst_sync[1];

   // ready follows ss, high when no frame is running
   always_ff @(posedge sclk or posedge spi_rst) begin
      if (spi_rst) begin
         ss_q  <= spi_pkg::spi_ready_rst;
         ready <= spi_pkg::spi_ready_rst;
      end else begin
         ss_q  <= ss;
         ready <= ss_q;
      end
   end

   // load while idle, shift right during the frame
   always_ff @(negedge sclk or posedge spi_rst) begin
      if (spi_rst) begin
         tx_shift <= '0;
      end else if (ss) begin
         tx_shift <= tx_word;
      end else begin
         tx_shift <= tx_shift >> 1;
      end
   end

   // LSB goes out first
   assign miso = tx_shift[0];

   // new bits enter at the top, so the first one ends in bit 0
   always_ff @(posedge sclk or posedge spi_rst) begin
      if (spi_rst) begin
         rx_word <= '0;
      end else if (!ss) begin
         rx_word <= {mosi, rx_word[DATA_W-1:1]};
      end
   end

endmodule

// ==== src/spi_slave_top.sv ====
// SPI slave with a memory-mapped control port
// joins the clk domain register file and the sclk domain shift engine;
// every crossing goes through a two-flop synchronizer
// tx crosses on sclk, rx and ready cross on clk
`timescale 1ns/1ps

module spi_slave_top #(
   parameter int DATA_W = spi_pkg::spi_data_w
) (
   input  logic                           clk,
   input  logic                           rst_int,

   // SPI pins
   input  logic                           sclk,
   input  logic                           ss,
   input  logic                           mosi,
   output logic                           miso,

   // CPU bus
   input  logic [spi_pkg::spi_addr_w-1:0] address,
   input  logic [DATA_W-1:0]              data_in,
   input  logic                           sel,
   input  logic                           read,
   input  logic                           write,
   output logic [DATA_W-1:0]              data_out
);

   // clk domain
   logic              rst_core;
   logic [DATA_W-1:0] tx_word;
   logic [DATA_W-1:0] rx_word_c;
   logic              ready_c;

   // sclk domain
   logic              spi_rst;
   logic [DATA_W-1:0] tx_word_s;
   logic [DATA_W-1:0] rx_word;
   logic              ready;

   spi_reg_file #(
      .DATA_W (DATA_W)
   ) u_regs (
      .clk      (clk),
      .rst_int  (rst_int),
      .address  (address),
      .data_in  (data_in),
      .sel      (sel),
      .read     (read),
      .write    (write),
      .data_out (data_out),
      .rx_word  (rx_word_c),
      .ready    (ready_c),
      .tx_word  (tx_word),
      .rst_core (rst_core)
   );

   spi_shift_engine #(
      .DATA_W (DATA_W)
   ) u_engine (
      .sclk    (sclk),
      .rst     (rst_core),
      .ss      (ss),
      .mosi    (mosi),
      .miso    (miso),
      .tx_word (tx_word_s),
      .rx_word (rx_word),
      .ready   (ready),
      .spi_rst (spi_rst)
   );

   // tx word into sclk
   spi_cdc_sync #(
      .T         (logic [DATA_W-1:0]),
      .RESET_VAL ('0)
   ) u_tx_sync (
      .clk (sclk),
      .rst (spi_rst),
      .d   (tx_word),
      .q   (tx_word_s)
   );

   // received word back into clk
   spi_cdc_sync #(
      .T         (logic [DATA_W-1:0]),
      .RESET_VAL ('0)
   ) u_rx_sync (
      .clk (clk),
      .rst (rst_core),
      .d   (rx_word),
      .q   (rx_word_c)
   );

   // ready reads 1 straight out of reset
   spi_cdc_sync #(
      .T         (logic),
      .RESET_VAL (spi_pkg::spi_ready_rst)
   ) u_ready_sync (
      .clk (clk),
      .rst (rst_core),
      .d   (ready),
      .q   (ready_c)
   );

endmodule

// ==== bench/spi_slave_sva.sv ====
// concurrent checks on the CPU register file of the SPI slave
// bound into every spi_reg_file instance by the bind at the bottom
// fail_count is read by the testbench for its final verdict
`timescale 1ns/1ps

module spi_slave_sva #(
   parameter int DATA_W = 32
) (
   input logic              clk,
   input logic              rst_int,
   input logic              sel,
   input logic              read,
   input logic [DATA_W-1:0] data_out,
   input logic              rst_core,
   input logic              ready
);

   // number of failed assertions
   int unsigned fail_count = 0;

   // bus stays quiet unless a read is selected
   bus_idle_zero: assert property (@(posedge clk) disable iff (rst_int)
      !(sel && read) |-> data_out == '0)
      else begin
         fail_count++;
         $error("data_out is not zero without a selected read");
      end

   // with the hard reset low, rst_core comes from the soft reset pulse only
   soft_rst_pulse: assert property (@(posedge clk) disable iff (rst_int)
      rst_core |=> !rst_core)
      else begin
         fail_count++;
         $error("soft reset pulse lasted more than one clk cycle");
      end

   ready_known: assert property (@(posedge clk) disable iff (rst_core)
      !$isunknown(ready))
      else begin
         fail_count++;
         $error("ready is unknown after reset");
      end

endmodule

bind spi_reg_file spi_slave_sva #(.DATA_W(DATA_W)) u_sva (
   .clk      (clk),
   .rst_int  (rst_int),
   .sel      (sel),
   .read     (read),
   .data_out (data_out),
   .rst_core (rst_core),
   .ready    (ready)
);

// ==== bench/spi_slave_tb.sv ====
// testbench for the SPI slave with its CPU register port
// runs reset values, scratch readback, transmit, receive with ready
// and soft reset; sclk runs all the time, frames are framed by ss
`timescale 1ns/1ps

module spi_slave_tb;

   localparam int dw = spi_pkg::spi_data_w;
   // tests take roughly 1600 clk cycles
   localparam int timeout_cycles = 3000;

   logic                           clk;
   logic                           rst_int;
   logic                           sclk;
   logic                           ss;
   logic                           mosi;
   logic                           miso;
   logic [spi_pkg::spi_addr_w-1:0] address;
   logic [dw-1:0]                  data_in;
   logic                           sel;
   logic                           read;
   logic                           write;
   logic [dw-1:0]                  data_out;

   int          errors = 0;
   int          tests = 0;
   int          cycles = 0;
   logic [31:0] lcg_state = 32'd61869;

   spi_slave_top #(
      .DATA_W (dw)
   ) u_dut (
      .clk      (clk),
      .rst_int  (rst_int),
      .sclk     (sclk),
      .ss       (ss),
      .mosi     (mosi),
      .miso     (miso),
      .address  (address),
      .data_in  (data_in),
      .sel      (sel),
      .read     (read),
      .write    (write),
      .data_out (data_out)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // master clock, free running at 400 ns
   initial begin
      sclk = 1'b0;
      forever #200 sclk = ~sclk;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= timeout_cycles) begin
         $display("run timed out after %0d clk cycles", cycles);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic check_equal(input string what, input logic [dw-1:0] got,
                              input logic [dw-1:0] exp);
      assert (got === exp) else begin
         $display("FAILED at %0t: %s expected %h got %h", $time, what, exp, got);
         errors++;
      end
   endtask

   task automatic end_test(input string name, input int errors_before);
      tests++;
      $display("test %s %s", name, (errors == errors_before) ? "ok" : "has errors");
   endtask

   // bus tasks start and end 10 ns after a rising clk edge
   task automatic bus_write(input logic [spi_pkg::spi_addr_w-1:0] addr,
                            input logic [dw-1:0] data);
      address = addr;
      data_in = data;
      sel     = 1'b1;
      write   = 1'b1;
      @(posedge clk);
      #10;
      sel     = 1'b0;
      write   = 1'b0;
   endtask

   task automatic bus_read(input logic [spi_pkg::spi_addr_w-1:0] addr,
                           input logic with_sel, output logic [dw-1:0] data);
      address = addr;
      sel     = with_sel;
      read    = 1'b1;
      #50;
      data    = data_out;
      @(posedge clk);
      #10;
      sel     = 1'b0;
      read    = 1'b0;
   endtask

   // n rising sclk edges, then back in step with the bus clock
   task automatic settle_sclk(input int n);
      repeat (n) @(posedge sclk);
      @(posedge clk);
      #10;
   endtask

   // one frame, mosi changes after falling edges, miso sampled after rising ones
   task automatic run_frame(input logic [dw-1:0] mosi_word,
                            output logic [dw-1:0] miso_word);
      int k;
      @(negedge sclk);
      #10;
      ss   = 1'b0;
      mosi = mosi_word[0];
      for (k = 0; k < dw; k++) begin
         @(posedge sclk);
         #10;
         miso_word[k] = miso;
         @(negedge sclk);
         #10;
         if (k < dw - 1) begin
            mosi = mosi_word[k+1];
         end
      end
      ss = 1'b1;
   endtask

   // poll ready for up to 4 sclk periods
   task automatic wait_ready();
      logic [dw-1:0] v;
      int            n;
      v = '0;
      n = 0;
      while (v[0] !== 1'b1 && n < 16) begin
         bus_read(spi_pkg::spi_addr_ready, 1'b1, v);
         n++;
      end
      check_equal("ready after frame", v, 1);
   endtask

   initial begin
      logic [dw-1:0] v;
      logic [dw-1:0] mid;
      logic [dw-1:0] word;
      logic [dw-1:0] seen;
      int            start;
      int            i;
      int            total;

      rst_int = 1'b1;
      ss      = 1'b1;
      mosi    = 1'b0;
      address = '0;
      data_in = '0;
      sel     = 1'b0;
      read    = 1'b0;
      write   = 1'b0;
      repeat (5) @(posedge clk);
      #10;
      rst_int = 1'b0;
      settle_sclk(3);

      start = errors;
      bus_read(spi_pkg::spi_addr_ready, 1'b1, v);
      check_equal("ready after reset", v, 1);
      bus_read(spi_pkg::spi_addr_rx, 1'b1, v);
      check_equal("rx after reset", v, 0);
      bus_read(spi_pkg::spi_addr_version, 1'b1, v);
      check_equal("version", v, dw'(spi_pkg::spi_version));
      bus_read(spi_pkg::spi_addr_scratch, 1'b1, v);
      check_equal("scratch after reset", v, 0);
      bus_read(3'd6, 1'b1, v);
      check_equal("unmapped address", v, 0);
      bus_read(spi_pkg::spi_addr_version, 1'b0, v);
      check_equal("read without sel", v, 0);
      end_test("reset values", start);

      start = errors;
      for (i = 0; i < 8; i++) begin
         word = next_random();
         bus_write(spi_pkg::spi_addr_scratch, word);
         bus_read(spi_pkg::spi_addr_scratch, 1'b1, v);
         check_equal("scratch readback", v, word);
      end
      end_test("scratch", start);

      start = errors;
      for (i = 0; i < 4; i++) begin
         word = next_random();
         bus_write(spi_pkg::spi_addr_tx, word);
         settle_sclk(4);
         run_frame('0, seen);
         check_equal("miso word", seen, word);
         settle_sclk(0);
      end
      end_test("transmit", start);

      start = errors;
      for (i = 0; i < 4; i++) begin
         word = (i == 1) ? '1 : (i == 2) ? '0 : next_random();
         fork
            run_frame(word, seen);
            begin
               settle_sclk(8);
               bus_read(spi_pkg::spi_addr_ready, 1'b1, mid);
               check_equal("ready during frame", mid, 0);
            end
         join
         settle_sclk(0);
         wait_ready();
         bus_read(spi_pkg::spi_addr_rx, 1'b1, v);
         check_equal("rx word", v, word);
      end
      end_test("receive", start);

      start = errors;
      bus_write(spi_pkg::spi_addr_scratch, next_random());
      bus_write(spi_pkg::spi_addr_tx, next_random());
      bus_write(spi_pkg::spi_addr_soft_rst, next_random());
      // sclk side needs two rising edges to leave reset
      settle_sclk(4);
      bus_read(spi_pkg::spi_addr_scratch, 1'b1, v);
      check_equal("scratch after soft reset", v, 0);
      bus_read(spi_pkg::spi_addr_ready, 1'b1, v);
      check_equal("ready after soft reset", v, 1);
      run_frame(next_random(), seen);
      check_equal("miso after soft reset", seen, 0);
      settle_sclk(0);
      wait_ready();
      end_test("soft reset", start);

      total = errors + int'(u_dut.u_regs.u_sva.fail_count);
      $display("%0d tests run, %0d errors", tests, total);
      if (total == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// ==== spi_slave_top.f ====
src/spi_pkg.sv
src/spi_cdc_sync.sv
src/spi_reg_file.sv
src/spi_shift_engine.sv
src/spi_slave_top.sv
bench/spi_slave_sva.sv
bench/spi_slave_tb.sv

// ==== Bender.yml ====
package:
  name: spi_slave

sources:
  - src/spi_pkg.sv
  - src/spi_cdc_sync.sv
  - src/spi_reg_file.sv
  - src/spi_shift_engine.sv
  - src/spi_slave_top.sv
  - target: test
    files:
      - bench/spi_slave_sva.sv
      - bench/spi_slave_tb.sv
